// File: mfifo_defines.svh
`ifndef MFIFO_DEFINES_SVH
`define MFIFO_DEFINES_SVH

// lane counts on either side of the queue
`define MFIFO_M 4
`define MFIFO_N 4
`define MFIFO_DEPTH 16 // power of two only

`define MFIFO_TAG_W 4
`define MFIFO_DATA_W 12

`endif

// File: mfifo_pkg.sv
`default_nettype none

`include "mfifo_defines.svh"

package mfifo_pkg;

  localparam int TAG_W  = `MFIFO_TAG_W;
  localparam int DATA_W = `MFIFO_DATA_W;
  localparam int PTR_W  = $clog2(`MFIFO_DEPTH);
  localparam int REQ_W  = $clog2(`MFIFO_N + 1); // 0..N inclusive

  // payload carried on every lane
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] data;
  } entry_t;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   cnt_t; // holds DEPTH itself
  typedef logic [REQ_W-1:0] req_t;

endpackage

`default_nettype wire

// File: mfifo_if.sv
`timescale 1ns/1ps
`default_nettype none

// producer side of the FIFO
// push lanes are contiguous from lane 0
interface fifo_push_if #(
  parameter type T = mfifo_pkg::entry_t,
  parameter int  M = 4
);
  logic [M-1:0] push;
  T     [M-1:0] datain;
  logic         full;
  logic [M-1:1] almost_full; // bit i set when fewer than i+1 slots are free

  modport src (output push, output datain, input full, input almost_full);
  modport dst (input push, input datain, output full, output almost_full);

endinterface

// consumer side of the FIFO
// pop lanes are contiguous from lane 0
interface fifo_pop_if #(
  parameter type T = mfifo_pkg::entry_t,
  parameter int  N = 4
);
  logic [N-1:0] pop;
  T     [N-1:0] dataout;  // head of queue in lane 0
  logic         empty;
  logic [N-1:1] almost_empty; // bit i set when at most i entries held

  modport req (output pop, input dataout, input empty, input almost_empty);
  modport dst (input pop, output dataout, output empty, output almost_empty);

endinterface

`default_nettype wire

// File: cdffr.sv
`timescale 1ns/1ps
`default_nettype none

// register with sync clear and load enable, clear wins over enable
module cdffr #(
  parameter int WIDTH = 1
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             c,
  input  wire logic             e,
  input  wire logic [WIDTH-1:0] d,
  output logic      [WIDTH-1:0] q
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (c) begin
      q <= '0;
    end else if (e) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// File: push_compactor.sv
`timescale 1ns/1ps
`default_nettype none

module push_compactor #(
  parameter type T = mfifo_pkg::entry_t,
  parameter int  M = 4
) (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic [M-1:0] in_valid,
  input  wire T     [M-1:0] in_data,
  fifo_push_if.src    push_if
);

  localparam int CNT_W = $clog2(M + 1);

  T     [M-1:0]     packed_data;
  logic [M-1:0]     packed_push;
  logic [CNT_W-1:0] free_lanes; // free slots seen through the flags, capped at M

  // k-th set input lane lands on output lane k
  always_comb begin
    int unsigned k;
    k = 0;
    packed_data = '0;
    packed_push = '0;
    for (int j = 0; j < M; j++) begin
      if (in_valid[j]) begin
        packed_data[k] = in_data[j];
        packed_push[k] = 1'b1;  // ends up as a thermometer of popcount
        k++;
      end
    end
  end

  assign push_if.push   = packed_push;
  assign push_if.datain = packed_data;

  always_comb begin
    free_lanes = CNT_W'(M);
    for (int i = M - 1; i >= 1; i--) begin
      if (push_if.almost_full[i]) free_lanes = CNT_W'(i);
    end
    if (push_if.full) free_lanes = '0;
  end

  // producer must stay within the space the FIFO advertises
  assert property (@(posedge clk) disable iff (!rst_n) $countones(in_valid) <= free_lanes)
    else $error("push_compactor: %0d valid lanes but only %0d free",
                $countones(in_valid), free_lanes);

endmodule

`default_nettype wire

// File: pop_limiter.sv
`timescale 1ns/1ps
`default_nettype none

module pop_limiter #(
  parameter int N = 4
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire mfifo_pkg::req_t req,
  fifo_pop_if.req              pop_if,
  output logic [N-1:0]         out_valid
);

  import mfifo_pkg::*;

  req_t         avail;  // occupancy as far as N lanes can see
  req_t         grant;
  logic [N-1:0] pop_mask;
  logic [N-1:0] held;   // lane i set while entry i is stored

  // almost_empty[i] first goes high at i == occupancy
  always_comb begin
    avail = req_t'(N);
    for (int i = N - 1; i >= 1; i--) begin
      if (pop_if.almost_empty[i]) avail = req_t'(i);
    end
    if (pop_if.empty) avail = '0;
  end

  assign grant = (req < avail) ? req : avail;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      pop_mask[i] = (req_t'(i) < grant);
    end
  end

  assign pop_if.pop = pop_mask;
  assign out_valid  = pop_mask;

  assign held = ~{pop_if.almost_empty, pop_if.empty};

  // occupancy decode expects the flags set from lane count upward
  assert property (@(posedge clk) disable iff (!rst_n)
                   ((held + 1'b1) & held) == '0)
    else $error("pop_limiter: empty flags give held lanes %b, not a thermometer code", held);

endmodule

`default_nettype wire

// File: multi_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// circular FIFO taking up to M entries and giving up to N entries per cycle
// push and pop may share a cycle, except when full
module multi_fifo #(
  parameter type T         = mfifo_pkg::entry_t,
  parameter int  M         = 4,
  parameter int  N         = 4,
  parameter int  DEPTH     = 16,
  parameter bit  POP_CLEAR = 1'b0  // zero a slot as it is popped
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        clear,
  fifo_push_if.dst         push_if,
  fifo_pop_if.dst          pop_if,
  output T [DEPTH-1:0]     fifo_data,  // ordered from the read pointer
  output mfifo_pkg::ptr_t  wptr,
  output mfifo_pkg::ptr_t  rptr
);

  import mfifo_pkg::*;

  localparam int PUSH_W = $clog2(M + 1);
  localparam int POP_W  = $clog2(N + 1);

  T mem [DEPTH];

  cnt_t              count;  // occupied entries
  cnt_t              next_count;
  ptr_t              next_wptr;
  ptr_t              next_rptr;
  logic [PUSH_W-1:0] push_cnt;
  logic [POP_W-1:0]  pop_cnt;
  logic [M-1:0]      push_block;  // lane j would overflow
  logic [N-1:0]      pop_block;   // lane j would underflow

  // pointers wrap on their own width
  if (DEPTH != (1 << $bits(ptr_t))) begin : g_bad_depth
    $error("multi_fifo: DEPTH %0d does not match ptr_t", DEPTH);
  end

  assign push_cnt = PUSH_W'($countones(push_if.push));
  assign pop_cnt  = POP_W'($countones(pop_if.pop));

  assign next_wptr  = wptr + ptr_t'(push_cnt);
  assign next_rptr  = rptr + ptr_t'(pop_cnt);
  assign next_count = count + cnt_t'(push_cnt) - cnt_t'(pop_cnt);

  cdffr #(.WIDTH($bits(ptr_t))) wptr_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .c     (clear),
    .e     (|push_if.push),
    .d     (next_wptr),
    .q     (wptr)
  );

  cdffr #(.WIDTH($bits(ptr_t))) rptr_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .c     (clear),
    .e     (|pop_if.pop),
    .d     (next_rptr),
    .q     (rptr)
  );

  cdffr #(.WIDTH($bits(cnt_t))) count_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .c     (clear),
    .e     ((|push_if.push) | (|pop_if.pop)),
    .d     (next_count),
    .q     (count)
  );

  assign push_block = {push_if.almost_full, push_if.full};
  assign pop_block  = {pop_if.almost_empty, pop_if.empty};

  // storage, no reset
  always_ff @(posedge clk) begin
    for (int j = 0; j < M; j++) begin
      if (push_if.push[j] && !push_block[j]) begin
        mem[wptr + ptr_t'(j)] <= push_if.datain[j];
      end
    end
    if (POP_CLEAR) begin
      if (clear) begin
        for (int j = 0; j < DEPTH; j++) begin
          mem[j] <= '0;
        end
      end else begin
        // popped slots never overlap the slots being written
        for (int j = 0; j < N; j++) begin
          if (pop_if.pop[j]) mem[rptr + ptr_t'(j)] <= '0;
        end
      end
    end
  end

  // flags from occupancy
  assign push_if.full = (count == cnt_t'(DEPTH));
  for (genvar i = 1; i < M; i++) begin : g_almost_full
    assign push_if.almost_full[i] = (int'(count) + i >= DEPTH);
  end

  assign pop_if.empty = (count == '0);
  for (genvar i = 1; i < N; i++) begin : g_almost_empty
    assign pop_if.almost_empty[i] = (int'(count) <= i);
  end

  // read-ordered view, head first
  for (genvar i = 0; i < DEPTH; i++) begin : g_view
    assign fifo_data[i] = mem[rptr + ptr_t'(i)];
  end

  for (genvar i = 0; i < N; i++) begin : g_dataout
    assign pop_if.dataout[i] = fifo_data[i];
  end

  // overflow on any push lane
  for (genvar i = 0; i < M; i++) begin : g_chk_push
    assert property (@(posedge clk) disable iff (!rst_n)
                     !(push_if.push[i] && push_block[i]))
      else $error("multi_fifo: overflow on push lane %0d", i);
  end

  // underflow on any pop lane
  for (genvar i = 0; i < N; i++) begin : g_chk_pop
    assert property (@(posedge clk) disable iff (!rst_n)
                     !(pop_if.pop[i] && pop_block[i]))
      else $error("multi_fifo: underflow on pop lane %0d", i);
  end

endmodule

`default_nettype wire

// File: mfifo_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mfifo_defines.svh"

module mfifo_top (
  input  wire logic                                   clk,
  input  wire logic                                   rst_n,
  input  wire logic                                   clear,
  input  wire logic              [`MFIFO_M-1:0]       in_valid,   // sparse
  input  wire mfifo_pkg::entry_t [`MFIFO_M-1:0]       in_data,
  output logic                                        in_full,
  output logic                   [`MFIFO_M-1:1]       in_almost_full,
  input  wire mfifo_pkg::req_t                        out_req,
  output logic                   [`MFIFO_N-1:0]       out_valid,
  output mfifo_pkg::entry_t      [`MFIFO_N-1:0]       out_data,
  output logic                                        out_empty,
  output mfifo_pkg::entry_t      [`MFIFO_DEPTH-1:0]   snapshot,
  output mfifo_pkg::ptr_t                             wptr,
  output mfifo_pkg::ptr_t                             rptr
);

  import mfifo_pkg::*;

  localparam int M     = `MFIFO_M;
  localparam int N     = `MFIFO_N;
  localparam int DEPTH = `MFIFO_DEPTH;

  fifo_push_if #(.T(entry_t), .M(M)) push_bus ();
  fifo_pop_if  #(.T(entry_t), .N(N)) pop_bus ();

  push_compactor #(.T(entry_t), .M(M)) push_compactor_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_data  (in_data),
    .push_if  (push_bus)
  );

  multi_fifo #(.T(entry_t), .M(M), .N(N), .DEPTH(DEPTH)) multi_fifo_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .push_if   (push_bus),
    .pop_if    (pop_bus),
    .fifo_data (snapshot),
    .wptr      (wptr),
    .rptr      (rptr)
  );

  pop_limiter #(.N(N)) pop_limiter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (out_req),
    .pop_if    (pop_bus),
    .out_valid (out_valid)
  );

  assign in_full        = push_bus.full;
  assign in_almost_full = push_bus.almost_full;
  assign out_data       = pop_bus.dataout;  // head first
  assign out_empty      = pop_bus.empty;

endmodule

`default_nettype wire

// File: tb_mfifo_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mfifo_defines.svh"

module tb_mfifo_top;

  import mfifo_pkg::*;

  localparam int M            = `MFIFO_M;
  localparam int N            = `MFIFO_N;
  localparam int DEPTH        = `MFIFO_DEPTH;
  localparam int RAND_CYCLES  = 300;
  localparam int FILL_CYCLES  = 12;
  localparam int DRAIN_CYCLES = 12;
  localparam int LIMIT = 16 + 2 * RAND_CYCLES + FILL_CYCLES + DRAIN_CYCLES + 100;

  logic                 clk;
  logic                 rst_n;
  logic                 clear;
  logic   [M-1:0]       in_valid;
  entry_t [M-1:0]       in_data;
  logic                 in_full;
  logic   [M-1:1]       in_almost_full;
  req_t                 out_req;
  logic   [N-1:0]       out_valid;
  entry_t [N-1:0]       out_data;
  logic                 out_empty;
  entry_t [DEPTH-1:0]   snapshot;
  ptr_t                 wptr;
  ptr_t                 rptr;

  entry_t model_q[$];  // reference queue, head at index 0
  integer seed = 74;
  int     cycle_cnt;
  bit     after_clear;

  mfifo_top mfifo_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .clear          (clear),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .in_full        (in_full),
    .in_almost_full (in_almost_full),
    .out_req        (out_req),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_empty      (out_empty),
    .snapshot       (snapshot),
    .wptr           (wptr),
    .rptr           (rptr)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("timeout: run still going after %0d cycles", LIMIT);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // low n lanes set
  function automatic logic [N-1:0] therm(input int n);
    therm = (n >= N) ? '1 : N'((1 << n) - 1);
  endfunction

  // random sparse mask, trimmed down to at most limit lanes
  task automatic pick_mask(input int limit, input bit dense, output logic [M-1:0] mask);
    int idx;
    mask = M'($random(seed));
    if (dense) mask = '1;
    while ($countones(mask) > limit) begin
      idx = $unsigned($random(seed)) % M;
      mask[idx] = 1'b0;
    end
  endtask

  task automatic check_outputs(input req_t req);
    int   occ;
    int   grant;
    ptr_t diff;
    occ   = model_q.size();
    grant = (int'(req) < occ) ? int'(req) : occ;
    check_value("out_valid", therm(grant), out_valid);
    check_value("out_empty", occ == 0, out_empty);
    check_value("in_full", occ == DEPTH, in_full);
    for (int i = 1; i < M; i++) begin
      check_value($sformatf("in_almost_full[%0d]", i), occ + i >= DEPTH, in_almost_full[i]);
    end
    for (int i = 0; i < grant; i++) begin
      check_value($sformatf("out_data[%0d]", i), model_q[i], out_data[i]);
    end
    for (int i = 0; i < occ; i++) begin
      check_value($sformatf("snapshot[%0d]", i), model_q[i], snapshot[i]);
    end
    diff = wptr - rptr;  // wraps at depth
    check_value("ptr_diff", (occ == DEPTH) ? 0 : occ, diff);
    if (after_clear) begin
      check_value("clear out_empty", 1, out_empty);
      check_value("clear wptr", 0, wptr);
      check_value("clear rptr", 0, rptr);
      after_clear = 1'b0;
    end
  endtask

  // state after the coming edge
  task automatic apply_model(input logic [M-1:0] v, input entry_t [M-1:0] d,
                             input req_t req, input bit clr);
    int grant;
    grant = (int'(req) < model_q.size()) ? int'(req) : model_q.size();
    if (clr) begin
      model_q.delete();  // clear overrides push and pop
      after_clear = 1'b1;
    end else begin
      repeat (grant) void'(model_q.pop_front());
      for (int j = 0; j < M; j++) begin
        if (v[j]) model_q.push_back(d[j]);  // ascending lane order
      end
    end
  endtask

  // mode 0 random, 1 fill without pops, 2 drain without pushes
  task automatic run_phase(input int cycles, input int mode);
    logic   [M-1:0] v;
    entry_t [M-1:0] d;
    req_t           req;
    bit             clr;
    int             free;
    repeat (cycles) begin
      @(posedge clk);
      free = DEPTH - model_q.size();
      pick_mask((free < M) ? free : M, mode == 1, v);
      if (mode == 2) v = '0;
      for (int j = 0; j < M; j++) d[j] = entry_t'($random(seed));
      req = (mode == 1) ? '0 : req_t'($unsigned($random(seed)) % (N + 1));
      clr = (mode == 0) && ($unsigned($random(seed)) % 40 == 0);  // rare
      in_valid <= v;
      in_data  <= d;
      out_req  <= req;
      clear    <= clr;
      @(negedge clk);
      check_outputs(req);
      apply_model(v, d, req, clr);
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    clear       = 1'b0;
    in_valid    = '0;
    in_data     = '0;
    out_req     = '0;
    cycle_cnt   = 0;
    after_clear = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset out_empty", 1, out_empty);
    check_value("reset in_full", 0, in_full);
    check_value("reset out_valid", 0, out_valid);
    check_value("reset wptr", 0, wptr);
    check_value("reset rptr", 0, rptr);
    run_phase(RAND_CYCLES, 0);
    run_phase(FILL_CYCLES, 1);
    run_phase(DRAIN_CYCLES, 2);
    run_phase(RAND_CYCLES, 0);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: mfifo_top.f
+incdir+.
mfifo_pkg.sv
mfifo_if.sv
cdffr.sv
push_compactor.sv
pop_limiter.sv
multi_fifo.sv
mfifo_top.sv
tb_mfifo_top.sv
